/* hw/dsp_pkg.sv */
package dsp_pkg;

    // Datapath word types
    typedef logic signed [7:0] code_t;
    typedef logic signed [7:0] weight_t;
    typedef logic signed [9:0] est_t;
    typedef logic signed [17:0] acc_t;
    typedef logic [2:0] shift_t;
    typedef logic signed [2:0] sym_t;

    // Configuration port types
    typedef logic [4:0] cfg_addr_t;
    typedef logic [9:0] cfg_data_t;

    // Register map bases, weights start at zero
    localparam cfg_addr_t shift_base_addr = 5'd12;
    localparam cfg_addr_t level_base_addr = 5'd16;
    localparam cfg_addr_t align_addr = 5'd19;

    // At least one estimate register, plus the output stage
    function automatic int total_depth_f(input int ffe_pipeline_depth);
        int base;
        base = (ffe_pipeline_depth > 1) ? ffe_pipeline_depth : 1;
        return base + 1;
    endfunction

endpackage

/* hw/dsp_cfg_if.sv */
interface dsp_cfg_if
    import dsp_pkg::*;
#(
    parameter int channel_width = 4,
    parameter int ffe_length = 3
);

    // Tap-major: weights[k][c] is tap k of lane c
    weight_t [ffe_length-1:0][channel_width-1:0] weights;
    shift_t [channel_width-1:0] ffe_shift;
    // Lowest level first
    est_t [2:0] slice_levels;
    logic [$clog2(channel_width)-1:0] align_pos;

    modport src (
        output weights,
        output ffe_shift,
        output slice_levels,
        output align_pos
    );

    modport dst (
        input weights,
        input ffe_shift,
        input slice_levels,
        input align_pos
    );

endinterface

/* hw/dsp_cfg_regs.sv */
module dsp_cfg_regs
    import dsp_pkg::*;
#(
    parameter int channel_width = 4,
    parameter int ffe_length = 3
) (
    input logic clk,
    input logic rst_n_i,
    input logic cfg_we_i,
    input cfg_addr_t cfg_addr_i,
    input cfg_data_t cfg_wdata_i,
    dsp_cfg_if.src cfg_o
);

    localparam int align_width = $clog2(channel_width);

    weight_t wdata_weight;
    shift_t wdata_shift;
    est_t wdata_level;

    assign wdata_weight = weight_t'(cfg_wdata_i[$bits(weight_t)-1:0]);
    assign wdata_shift = shift_t'(cfg_wdata_i[$bits(shift_t)-1:0]);
    assign wdata_level = est_t'(cfg_wdata_i);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_o.weights <= '0;
            cfg_o.ffe_shift <= '0;
            cfg_o.slice_levels <= '0;
            cfg_o.align_pos <= '0;
        end else if (cfg_we_i) begin
            for (int k = 0; k < ffe_length; k++) begin
                for (int c = 0; c < channel_width; c++) begin
                    if (int'(cfg_addr_i) == k * channel_width + c) begin
                        cfg_o.weights[k][c] <= wdata_weight;
                    end
                end
            end
            for (int c = 0; c < channel_width; c++) begin
                if (int'(cfg_addr_i) == int'(shift_base_addr) + c) begin
                    cfg_o.ffe_shift[c] <= wdata_shift;
                end
            end
            for (int l = 0; l < 3; l++) begin
                if (int'(cfg_addr_i) == int'(level_base_addr) + l) begin
                    cfg_o.slice_levels[l] <= wdata_level;
                end
            end
            // Anything else in the map is silently dropped
            if (cfg_addr_i == align_addr) begin
                cfg_o.align_pos <= cfg_wdata_i[align_width-1:0];
            end
        end
    end

endmodule

/* hw/code_pipeline.sv */
module code_pipeline #(
    parameter int channel_width = 4,
    parameter int bitwidth = 8,
    parameter int depth = 2
) (
    input logic clk,
    input logic rst_n_i,
    input logic signed [channel_width-1:0][bitwidth-1:0] data_i,
    output logic signed [depth:0][channel_width-1:0][bitwidth-1:0] stages_o
);

    // delay_regs[k] holds the input from k cycles back
    logic [depth:1][channel_width-1:0][bitwidth-1:0] delay_regs;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            delay_regs <= '0;
        end else begin
            delay_regs[1] <= data_i;
            for (int k = 2; k <= depth; k++) begin
                delay_regs[k] <= delay_regs[k-1];
            end
        end
    end

    // Stage 0 is the live input
    assign stages_o = {delay_regs, data_i};

endmodule

/* hw/comb_ffe.sv */
module comb_ffe
    import dsp_pkg::*;
#(
    parameter int channel_width = 4,
    parameter int ffe_length = 3
) (
    input code_t [2*channel_width-1:0] codes_i,
    input weight_t [ffe_length-1:0][channel_width-1:0] weights_i,
    input shift_t [channel_width-1:0] shift_i,
    output est_t [channel_width-1:0] est_o
);

    localparam acc_t est_max = acc_t'(2 ** ($bits(est_t) - 1) - 1);
    localparam acc_t est_min = -est_max - acc_t'(1);

    always_comb begin
        acc_t acc;
        acc_t shifted;
        logic signed [$bits(weight_t)+$bits(code_t)-1:0] prod;

        for (int c = 0; c < channel_width; c++) begin
            acc = '0;
            // Tap k looks k samples back, crossing into the older cycle for small c
            for (int k = 0; k < ffe_length; k++) begin
                prod = weights_i[k][c] * codes_i[channel_width+c-k];
                acc = acc + acc_t'(prod);
            end
            shifted = acc >>> shift_i[c];
            if (shifted > est_max) begin
                est_o[c] = est_t'(est_max);
            end else if (shifted < est_min) begin
                est_o[c] = est_t'(est_min);
            end else begin
                est_o[c] = est_t'(shifted);
            end
        end
    end

endmodule

/* hw/comb_slicer.sv */
module comb_slicer
    import dsp_pkg::*;
#(
    parameter int channel_width = 4
) (
    input est_t [channel_width-1:0] est_i,
    input est_t [2:0] levels_i,
    output sym_t [channel_width-1:0] sym_o
);

    localparam sym_t sym_p3 = 3'sd3;
    localparam sym_t sym_p1 = 3'sd1;
    localparam sym_t sym_m1 = -3'sd1;
    localparam sym_t sym_m3 = -3'sd3;

    // Strict compare, so an estimate on a level goes to the lower symbol
    always_comb begin
        for (int c = 0; c < channel_width; c++) begin
            if (est_i[c] > levels_i[2]) begin
                sym_o[c] = sym_p3;
            end else if (est_i[c] > levels_i[1]) begin
                sym_o[c] = sym_p1;
            end else if (est_i[c] > levels_i[0]) begin
                sym_o[c] = sym_m1;
            end else begin
                sym_o[c] = sym_m3;
            end
        end
    end

endmodule

/* hw/data_aligner.sv */
module data_aligner #(
    parameter int channel_width = 4,
    parameter int bitwidth = 8
) (
    input logic signed [2*channel_width-1:0][bitwidth-1:0] segment_i,
    input logic [$clog2(channel_width)-1:0] align_pos_i,
    output logic signed [channel_width-1:0][bitwidth-1:0] aligned_o
);

    // Window of channel_width lanes starting at align_pos_i, older half at the bottom
    always_comb begin
        for (int i = 0; i < channel_width; i++) begin
            aligned_o[i] = segment_i[int'(align_pos_i) + i];
        end
    end

endmodule

/* hw/bits_estimator_datapath.sv */
module bits_estimator_datapath
    import dsp_pkg::*;
#(
    parameter int channel_width = 4,
    parameter int ffe_length = 3,
    parameter int ffe_pipeline_depth = 1
) (
    input logic clk,
    input logic rst_n_i,
    input code_t [channel_width-1:0] act_codes_i,
    dsp_cfg_if.dst cfg_i,
    output code_t [channel_width-1:0] act_codes_o,
    output est_t [channel_width-1:0] est_syms_o,
    output est_t [channel_width-1:0] aligned_est_o,
    output sym_t [channel_width-1:0] symbols_o
);

    localparam int total_depth = total_depth_f(ffe_pipeline_depth);

    code_t [total_depth:0][channel_width-1:0] code_stages;
    code_t [2*channel_width-1:0] ffe_codes;
    est_t [channel_width-1:0] ffe_est;
    est_t [total_depth:0][channel_width-1:0] est_stages;
    est_t [2*channel_width-1:0] flat_est;
    sym_t [channel_width-1:0] slice_sym;
    sym_t [1:0][channel_width-1:0] sym_stages;
    sym_t [2*channel_width-1:0] flat_sym;

    // ADC code delay line, also feeds the FFE history
    code_pipeline #(
        .channel_width(channel_width),
        .bitwidth($bits(code_t)),
        .depth(total_depth)
    ) u_code_pipe (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .data_i(act_codes_i),
        .stages_o(code_stages)
    );

    assign act_codes_o = code_stages[total_depth];

    // Previous cycle in the low lanes, current cycle above
    assign ffe_codes = {code_stages[0], code_stages[1]};

    comb_ffe #(
        .channel_width(channel_width),
        .ffe_length(ffe_length)
    ) u_ffe (
        .codes_i(ffe_codes),
        .weights_i(cfg_i.weights),
        .shift_i(cfg_i.ffe_shift),
        .est_o(ffe_est)
    );

    code_pipeline #(
        .channel_width(channel_width),
        .bitwidth($bits(est_t)),
        .depth(total_depth)
    ) u_est_pipe (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .data_i(ffe_est),
        .stages_o(est_stages)
    );

    assign est_syms_o = est_stages[total_depth];

    comb_slicer #(
        .channel_width(channel_width)
    ) u_slicer (
        .est_i(est_stages[ffe_pipeline_depth]),
        .levels_i(cfg_i.slice_levels),
        .sym_o(slice_sym)
    );

    code_pipeline #(
        .channel_width(channel_width),
        .bitwidth($bits(sym_t)),
        .depth(1)
    ) u_sym_pipe (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .data_i(slice_sym),
        .stages_o(sym_stages)
    );

    // Both aligners see the older cycle in the lower half
    assign flat_est = {est_stages[ffe_pipeline_depth], est_stages[ffe_pipeline_depth+1]};
    assign flat_sym = {sym_stages[0], sym_stages[1]};

    data_aligner #(
        .channel_width(channel_width),
        .bitwidth($bits(est_t))
    ) u_est_align (
        .segment_i(flat_est),
        .align_pos_i(cfg_i.align_pos),
        .aligned_o(aligned_est_o)
    );

    data_aligner #(
        .channel_width(channel_width),
        .bitwidth($bits(sym_t))
    ) u_sym_align (
        .segment_i(flat_sym),
        .align_pos_i(cfg_i.align_pos),
        .aligned_o(symbols_o)
    );

endmodule

/* hw/rx_dsp_top.sv */
module rx_dsp_top
    import dsp_pkg::*;
#(
    parameter int channel_width = 4,
    parameter int ffe_length = 3,
    parameter int ffe_pipeline_depth = 1
) (
    input logic clk,
    input logic rst_n_i,
    input logic cfg_we_i,
    input cfg_addr_t cfg_addr_i,
    input cfg_data_t cfg_wdata_i,
    input code_t [channel_width-1:0] act_codes_i,
    output code_t [channel_width-1:0] act_codes_o,
    output est_t [channel_width-1:0] est_syms_o,
    output est_t [channel_width-1:0] aligned_est_o,
    output sym_t [channel_width-1:0] symbols_o
);

    dsp_cfg_if #(
        .channel_width(channel_width),
        .ffe_length(ffe_length)
    ) u_cfg_if ();

    dsp_cfg_regs #(
        .channel_width(channel_width),
        .ffe_length(ffe_length)
    ) u_cfg_regs (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .cfg_we_i(cfg_we_i),
        .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i),
        .cfg_o(u_cfg_if.src)
    );

    bits_estimator_datapath #(
        .channel_width(channel_width),
        .ffe_length(ffe_length),
        .ffe_pipeline_depth(ffe_pipeline_depth)
    ) u_datapath (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .act_codes_i(act_codes_i),
        .cfg_i(u_cfg_if.dst),
        .act_codes_o(act_codes_o),
        .est_syms_o(est_syms_o),
        .aligned_est_o(aligned_est_o),
        .symbols_o(symbols_o)
    );

endmodule

/* sim/rx_dsp_props.sv */
module rx_dsp_props
    import dsp_pkg::*;
#(
    parameter int channel_width = 4,
    parameter int ffe_length = 3,
    parameter int ffe_pipeline_depth = 1
) (
    input logic clk,
    input logic rst_n_i,
    input code_t [channel_width-1:0] act_codes_i,
    input code_t [channel_width-1:0] act_codes_o,
    input weight_t [ffe_length-1:0][channel_width-1:0] weights_i,
    input shift_t [channel_width-1:0] shift_i,
    input est_t [2:0] levels_i,
    input logic [$clog2(channel_width)-1:0] align_pos_i,
    input sym_t [channel_width-1:0] symbols_o,
    input est_t [channel_width-1:0] aligned_est_o
);

    localparam int depth = total_depth_f(ffe_pipeline_depth);

    int run_cnt;
    int steady_cnt;
    code_t [channel_width-1:0] prev_codes;
    weight_t [ffe_length-1:0][channel_width-1:0] prev_weights;
    shift_t [channel_width-1:0] prev_shift;
    est_t [2:0] prev_levels;
    logic [$clog2(channel_width)-1:0] prev_align;
    logic inputs_same;

    assign inputs_same = (act_codes_i == prev_codes) && (weights_i == prev_weights) &&
        (shift_i == prev_shift) && (levels_i == prev_levels) && (align_pos_i == prev_align);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_cnt <= 0;
            steady_cnt <= 0;
            prev_codes <= '0;
            prev_weights <= '0;
            prev_shift <= '0;
            prev_levels <= '0;
            prev_align <= '0;
        end else begin
            if (run_cnt < 15) begin
                run_cnt <= run_cnt + 1;
            end
            if (!inputs_same) begin
                steady_cnt <= 0;
            end else if (steady_cnt < 15) begin
                steady_cnt <= steady_cnt + 1;
            end
            prev_codes <= act_codes_i;
            prev_weights <= weights_i;
            prev_shift <= shift_i;
            prev_levels <= levels_i;
            prev_align <= align_pos_i;
        end
    end

    a_code_delay: assert property (@(posedge clk) disable iff (!rst_n_i)
        run_cnt >= depth |-> act_codes_o == $past(act_codes_i, depth))
        else $error("act_codes_o does not match delayed input");

    // Older symbol half holds its reset value until the first edge
    for (genvar c = 0; c < channel_width; c++) begin : g_sym
        a_sym_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
            run_cnt >= 1 |-> symbols_o[c] inside {3'sd3, 3'sd1, -3'sd1, -3'sd3})
            else $error("symbol output is not a PAM4 level");
    end

    a_steady_out: assert property (@(posedge clk) disable iff (!rst_n_i)
        (steady_cnt >= depth + 1 && inputs_same) |->
            ($stable(symbols_o) && $stable(aligned_est_o)))
        else $error("outputs moved while inputs were steady");

endmodule

bind bits_estimator_datapath rx_dsp_props #(
    .channel_width(channel_width),
    .ffe_length(ffe_length),
    .ffe_pipeline_depth(ffe_pipeline_depth)
) u_props (
    .clk(clk),
    .rst_n_i(rst_n_i),
    .act_codes_i(act_codes_i),
    .act_codes_o(act_codes_o),
    .weights_i(cfg_i.weights),
    .shift_i(cfg_i.ffe_shift),
    .levels_i(cfg_i.slice_levels),
    .align_pos_i(cfg_i.align_pos),
    .symbols_o(symbols_o),
    .aligned_est_o(aligned_est_o)
);

/* sim/tb_rx_dsp_top.sv */
module tb_rx_dsp_top
    import dsp_pkg::*;
();

    localparam int lanes = 4;
    localparam int taps = 3;
    // Output delay with the default FFE pipeline depth of 1
    localparam int depth = 2;
    localparam int n_rows = 6;

    typedef struct {
        int wmode;
        int shift;
        int lv0;
        int lv1;
        int lv2;
        int align;
        int cmode;
        int cycles;
    } row_t;

    logic clk;
    logic rst_n_i;
    logic cfg_we_i;
    cfg_addr_t cfg_addr_i;
    cfg_data_t cfg_wdata_i;
    code_t [lanes-1:0] act_codes_i;
    code_t [lanes-1:0] act_codes_o;
    est_t [lanes-1:0] est_syms_o;
    est_t [lanes-1:0] aligned_est_o;
    sym_t [lanes-1:0] symbols_o;

    row_t rows[n_rows];
    logic table_ready = 1'b0;
    int w_m[taps][lanes];
    int sh_m[lanes];
    int lv_m[3];
    int al_m;
    code_t [lanes-1:0] hist[$];
    int level_pts[8] = '{-64, -63, 0, 1, 64, 65, -128, 127};

    rx_dsp_top u_rx_dsp_top (
        .clk(clk),
        .rst_n_i(rst_n_i),
        .cfg_we_i(cfg_we_i),
        .cfg_addr_i(cfg_addr_i),
        .cfg_wdata_i(cfg_wdata_i),
        .act_codes_i(act_codes_i),
        .act_codes_o(act_codes_o),
        .est_syms_o(est_syms_o),
        .aligned_est_o(aligned_est_o),
        .symbols_o(symbols_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Sample s is lane s%4 of input cycle s/4
    function automatic int code_at(int s);
        if (s < 0) begin
            return 0;
        end
        return int'(hist[s / lanes][s % lanes]);
    endfunction

    function automatic int est_of(int n, int c);
        int sum;
        int v;
        if (n < 0) begin
            return 0;
        end
        sum = 0;
        for (int k = 0; k < taps; k++) begin
            sum += w_m[k][c] * code_at(n * lanes + c - k);
        end
        v = sum >>> sh_m[c];
        if (v > 511) begin
            return 511;
        end
        return (v < -512) ? -512 : v;
    endfunction

    function automatic int est_at(int s);
        if (s < 0) begin
            return 0;
        end
        return est_of(s / lanes, s % lanes);
    endfunction

    function automatic int slice_of(int e);
        if (e > lv_m[2]) begin
            return 3;
        end else if (e > lv_m[1]) begin
            return 1;
        end else if (e > lv_m[0]) begin
            return -1;
        end
        return -3;
    endfunction

    function automatic code_t gen_code(int mode, int n, int c);
        if (mode == 0) begin
            return code_t'($urandom_range(0, 255));
        end else if (mode == 1) begin
            return ((n / 2) % 2 == 0) ? 8'sd127 : -8'sd128;
        end
        return code_t'(level_pts[(n * lanes + c) % 8]);
    endfunction

    task automatic check_val(string name, int exp_v, int act_v);
        if (exp_v != act_v) begin
            $display("[FAIL] %s expected %h got %h", name, exp_v, act_v);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // One clock: inputs change shortly after the rising edge
    task automatic step(logic we, int addr, int data, code_t [lanes-1:0] codes);
        @(posedge clk);
        #1;
        cfg_we_i = we;
        cfg_addr_i = cfg_addr_t'(addr);
        cfg_wdata_i = cfg_data_t'(data);
        act_codes_i = codes;
        hist.push_back(codes);
    endtask

    task automatic apply_config(row_t r);
        for (int k = 0; k < taps; k++) begin
            for (int c = 0; c < lanes; c++) begin
                if (r.wmode == 0) begin
                    w_m[k][c] = int'($urandom_range(0, 255)) - 128;
                end else if (r.wmode == 1) begin
                    w_m[k][c] = 127;
                end else begin
                    w_m[k][c] = (k == 0) ? 1 : 0;
                end
                step(1'b1, k * lanes + c, w_m[k][c], '0);
            end
        end
        for (int c = 0; c < lanes; c++) begin
            sh_m[c] = (r.shift < 0) ? int'($urandom_range(0, 7)) : r.shift;
            step(1'b1, 12 + c, sh_m[c], '0);
        end
        lv_m = '{r.lv0, r.lv1, r.lv2};
        for (int l = 0; l < 3; l++) begin
            step(1'b1, 16 + l, lv_m[l], '0);
        end
        al_m = r.align;
        step(1'b1, 19, al_m, '0);
        repeat (4) step(1'b0, 0, 0, '0);
    endtask

    task automatic stream_row(row_t r);
        code_t [lanes-1:0] codes;
        int n;
        int s;
        for (int i = 0; i < r.cycles; i++) begin
            for (int c = 0; c < lanes; c++) begin
                codes[c] = gen_code(r.cmode, i, c);
            end
            step(1'b0, 0, 0, codes);
            #2;
            n = hist.size() - 1;
            for (int c = 0; c < lanes; c++) begin
                s = (n - depth) * lanes + al_m + c;
                check_val($sformatf("act_codes_o[%0d]", c),
                    code_at((n - depth) * lanes + c), int'(act_codes_o[c]));
                check_val($sformatf("est_syms_o[%0d]", c),
                    est_of(n - depth, c), int'(est_syms_o[c]));
                check_val($sformatf("aligned_est_o[%0d]", c), est_at(s), int'(aligned_est_o[c]));
                check_val($sformatf("symbols_o[%0d]", c), slice_of(est_at(s)),
                    int'(symbols_o[c]));
            end
        end
    endtask

    initial begin
        int limit;
        wait (table_ready);
        limit = 5;
        for (int i = 0; i < n_rows; i++) begin
            limit += rows[i].cycles + 25;
        end
        #(2 * limit * 8);
        $display("Timeout: the test did not finish within the expected time");
        $display("Errors found");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'h6077c1f6));
        rst_n_i = 1'b0;
        cfg_we_i = 1'b0;
        cfg_addr_i = '0;
        cfg_wdata_i = '0;
        act_codes_i = '0;
        // wmode, shift, levels, align, code mode, cycles
        rows[0] = '{0, -1, -200, 0, 200, 0, 0, 40};
        rows[1] = '{1, 0, -100, 0, 100, 0, 1, 12};
        rows[2] = '{2, 0, -64, 0, 64, 0, 2, 8};
        rows[3] = '{0, -1, -100, 20, 90, 1, 0, 16};
        rows[4] = '{2, 0, -64, 0, 64, 2, 2, 16};
        rows[5] = '{0, -1, -100, 20, 90, 3, 0, 16};
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        #1;
        for (int c = 0; c < lanes; c++) begin
            check_val($sformatf("act_codes_o[%0d]", c), 0, int'(act_codes_o[c]));
            check_val($sformatf("est_syms_o[%0d]", c), 0, int'(est_syms_o[c]));
            check_val($sformatf("aligned_est_o[%0d]", c), 0, int'(aligned_est_o[c]));
        end
        for (int i = 0; i < n_rows; i++) begin
            apply_config(rows[i]);
            stream_row(rows[i]);
        end
        $display("No errors");
        $finish;
    end

endmodule

/* compile.f */
hw/dsp_pkg.sv
hw/dsp_cfg_if.sv
hw/dsp_cfg_regs.sv
hw/code_pipeline.sv
hw/comb_ffe.sv
hw/comb_slicer.sv
hw/data_aligner.sv
hw/bits_estimator_datapath.sv
hw/rx_dsp_top.sv
sim/rx_dsp_props.sv
sim/tb_rx_dsp_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rx_dsp_top testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rx_dsp_top \
    -f compile.f

./obj_dir/Vtb_rx_dsp_top 2>&1 | tee sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    exit 1
fi
exit 0
